//--- source/opb_bus_pkg.sv
package opb_bus_pkg;

  localparam int opb_addr_width  = 32;
  localparam int opb_data_width  = 32;
  localparam int opb_be_width    = opb_data_width / 8;
  localparam int reg_index_width = 8;

  // Word index starts at this offset bit
  localparam int reg_index_lsb = 2;

  typedef logic [opb_addr_width-1:0]  opb_addr_t;
  typedef logic [opb_data_width-1:0]  opb_data_t;
  typedef logic [opb_be_width-1:0]    opb_be_t;
  typedef logic [reg_index_width-1:0] reg_index_t;

  // 1 KB register window, base included and high address excluded
  localparam opb_addr_t opb_base_addr = 32'h0002_0000;
  localparam opb_addr_t opb_high_addr = 32'h0002_0400;

endpackage

//--- source/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

  typedef logic [3:0]  state_code_t;
  typedef logic [31:0] ctr_value_t;

  // DRAM states 0 to 7 and OPB states 0 to 5 have their own counter, plus one SX each
  localparam int ddr3_ctr_num = 9;
  localparam int opb_ctr_num  = 7;

  typedef ctr_value_t [ddr3_ctr_num-1:0] ddr3_ctr_array_t;
  typedef ctr_value_t [opb_ctr_num-1:0]  opb_ctr_array_t;

  typedef logic [$clog2(ddr3_ctr_num)-1:0] ddr3_ctr_sel_t;
  typedef logic [$clog2(opb_ctr_num)-1:0]  opb_ctr_sel_t;

  // ==========================================================================
  // Register word indices
  // ==========================================================================
  localparam opb_bus_pkg::reg_index_t reg_softaddr     = 8'd0;
  localparam opb_bus_pkg::reg_index_t reg_phyready     = 8'd1;
  localparam opb_bus_pkg::reg_index_t reg_override     = 8'd2;
  localparam opb_bus_pkg::reg_index_t reg_arbstate     = 8'd3;
  localparam opb_bus_pkg::reg_index_t reg_memstate     = 8'd4;
  localparam opb_bus_pkg::reg_index_t reg_ddr3_s0      = 8'd5;
  localparam opb_bus_pkg::reg_index_t reg_ddr3_s1      = 8'd6;
  localparam opb_bus_pkg::reg_index_t reg_ddr3_s2      = 8'd7;
  localparam opb_bus_pkg::reg_index_t reg_ddr3_s3      = 8'd8;
  localparam opb_bus_pkg::reg_index_t reg_ddr3_s4      = 8'd9;
  localparam opb_bus_pkg::reg_index_t reg_ddr3_s5      = 8'd10;
  localparam opb_bus_pkg::reg_index_t reg_ddr3_s6      = 8'd11;
  localparam opb_bus_pkg::reg_index_t reg_ddr3_s7      = 8'd12;
  localparam opb_bus_pkg::reg_index_t reg_ddr3_sx      = 8'd13;
  localparam opb_bus_pkg::reg_index_t reg_opb_s0       = 8'd14;
  localparam opb_bus_pkg::reg_index_t reg_opb_s1       = 8'd15;
  localparam opb_bus_pkg::reg_index_t reg_opb_s2       = 8'd16;
  localparam opb_bus_pkg::reg_index_t reg_opb_s3       = 8'd17;
  localparam opb_bus_pkg::reg_index_t reg_opb_s4       = 8'd18;
  localparam opb_bus_pkg::reg_index_t reg_opb_s5       = 8'd19;
  localparam opb_bus_pkg::reg_index_t reg_opb_sx       = 8'd20;
  localparam opb_bus_pkg::reg_index_t reg_opb_ctr_rst  = 8'd21;
  localparam opb_bus_pkg::reg_index_t reg_ddr3_ctr_rst = 8'd22;
  localparam opb_bus_pkg::reg_index_t reg_opb_addr_lil = 8'd23;
  localparam opb_bus_pkg::reg_index_t reg_opb_addr_big = 8'd24;

endpackage

//--- source/opb_reg_if.sv
`timescale 1ns/1ps

interface opb_reg_if;

  logic                   req;
  logic                   rnw;
  opb_bus_pkg::reg_index_t index;
  opb_bus_pkg::opb_be_t    be;
  opb_bus_pkg::opb_data_t  wdata;
  opb_bus_pkg::opb_data_t  rdata;
  logic                   ack;
  logic                   err;

  // Bus side issues the access
  modport decoder (output req, rnw, index, be, wdata, input rdata, ack, err);

  // Register side answers one cycle after req
  modport regs (input req, rnw, index, be, wdata, output rdata, ack, err);

endinterface

//--- source/opb_slave_decode.sv
`timescale 1ns/1ps

module opb_slave_decode (
  input  logic                                   OPB_Clk,
  input  logic                                   rst_n,
  input  logic [0:opb_bus_pkg::opb_addr_width-1] OPB_ABus,
  input  logic [0:opb_bus_pkg::opb_be_width-1]   OPB_BE,
  input  logic [0:opb_bus_pkg::opb_data_width-1] OPB_DBus,
  input  logic                                   OPB_RNW,
  input  logic                                   OPB_select,
  output logic [0:opb_bus_pkg::opb_data_width-1] Sl_DBus,
  output logic                                   Sl_xferAck,
  output logic                                   Sl_errAck,
  output logic                                   Sl_retry,
  output logic                                   Sl_toutSup,
  opb_reg_if.decoder                             bus
);

  typedef enum logic [1:0] {idle, wait_resp, wait_release} dec_state_t;

  dec_state_t             state;
  opb_bus_pkg::opb_addr_t addr;
  opb_bus_pkg::opb_addr_t offset;
  logic                   in_range;

  // OPB numbers bits MSB first, so plain assignment to a [n:0] vector flips the indices
  assign addr     = OPB_ABus;
  assign offset   = addr - opb_bus_pkg::opb_base_addr;
  assign in_range = (addr >= opb_bus_pkg::opb_base_addr) &&
                    (addr < opb_bus_pkg::opb_high_addr);

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      state   <= idle;
      bus.req <= 1'b0;
    end else begin
      bus.req <= 1'b0;
      case (state)
        idle: begin
          if (OPB_select && in_range) begin
            bus.req <= 1'b1;
            state   <= wait_resp;
          end
        end
        wait_resp: begin
          if (bus.ack || bus.err) begin
            state <= wait_release;
          end
        end
        // Master must drop select before the next access is taken
        wait_release: begin
          if (!OPB_select) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (state == idle && OPB_select) begin
      bus.rnw   <= OPB_RNW;
      bus.index <= offset[opb_bus_pkg::reg_index_lsb +: opb_bus_pkg::reg_index_width];
      bus.be    <= OPB_BE;
      bus.wdata <= OPB_DBus;
    end
  end

  // Response goes straight back onto the bus
  assign Sl_DBus    = bus.rdata;
  assign Sl_xferAck = bus.ack;
  assign Sl_errAck  = bus.err;
  assign Sl_retry   = 1'b0;
  assign Sl_toutSup = 1'b0;

endmodule

//--- source/state_occupancy_counters.sv
`timescale 1ns/1ps

module state_occupancy_counters (
  input  logic                          OPB_Clk,
  input  logic                          rst_n,
  input  mem_ctrl_pkg::state_code_t     mem_dram_state,
  input  mem_ctrl_pkg::state_code_t     mem_opb_state,
  input  logic                          opb_ctr_rst,
  input  logic                          ddr3_ctr_rst,
  output mem_ctrl_pkg::ddr3_ctr_array_t ddr3_ctrs,
  output mem_ctrl_pkg::opb_ctr_array_t  opb_ctrs
);

  mem_ctrl_pkg::ddr3_ctr_sel_t ddr3_sel;
  mem_ctrl_pkg::opb_ctr_sel_t  opb_sel;

  // The top counter of each bank collects every code without a counter of its own
  always_comb begin
    if (int'(mem_dram_state) < mem_ctrl_pkg::ddr3_ctr_num - 1) begin
      ddr3_sel = mem_ctrl_pkg::ddr3_ctr_sel_t'(mem_dram_state);
    end else begin
      ddr3_sel = mem_ctrl_pkg::ddr3_ctr_sel_t'(mem_ctrl_pkg::ddr3_ctr_num - 1);
    end
  end

  always_comb begin
    if (int'(mem_opb_state) < mem_ctrl_pkg::opb_ctr_num - 1) begin
      opb_sel = mem_ctrl_pkg::opb_ctr_sel_t'(mem_opb_state);
    end else begin
      opb_sel = mem_ctrl_pkg::opb_ctr_sel_t'(mem_ctrl_pkg::opb_ctr_num - 1);
    end
  end

  // ==========================================================================
  // Counter banks, held at zero while their clear level is high
  // ==========================================================================
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      ddr3_ctrs <= '0;
    end else if (ddr3_ctr_rst) begin
      ddr3_ctrs <= '0;
    end else begin
      ddr3_ctrs[ddr3_sel] <= ddr3_ctrs[ddr3_sel] + 1'b1;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      opb_ctrs <= '0;
    end else if (opb_ctr_rst) begin
      opb_ctrs <= '0;
    end else begin
      opb_ctrs[opb_sel] <= opb_ctrs[opb_sel] + 1'b1;
    end
  end

endmodule

//--- source/ctrl_reg_file.sv
`timescale 1ns/1ps

module ctrl_reg_file (
  input  logic                          OPB_Clk,
  input  logic                          rst_n,
  opb_reg_if.regs                       bus,
  input  mem_ctrl_pkg::ddr3_ctr_array_t ddr3_ctrs,
  input  mem_ctrl_pkg::opb_ctr_array_t  opb_ctrs,
  input  mem_ctrl_pkg::state_code_t     mem_dram_state,
  input  mem_ctrl_pkg::state_code_t     mem_opb_state,
  input  mem_ctrl_pkg::state_code_t     arbiter_state,
  input  logic                          arbiter_conflict,
  input  logic                          phy_ready,
  input  opb_bus_pkg::opb_data_t        ctrl_opb_addr_lil,
  input  opb_bus_pkg::opb_data_t        ctrl_opb_addr_big,
  output opb_bus_pkg::opb_data_t        software_address_bits,
  output logic                          cpu_override_en,
  output logic                          cpu_override_sel,
  output logic                          opb_ctr_rst,
  output logic                          ddr3_ctr_rst
);

  opb_bus_pkg::opb_data_t      rd_word;
  logic                        hit;
  mem_ctrl_pkg::ddr3_ctr_sel_t ddr3_off;
  mem_ctrl_pkg::opb_ctr_sel_t  opb_off;

  assign ddr3_off = mem_ctrl_pkg::ddr3_ctr_sel_t'(bus.index - mem_ctrl_pkg::reg_ddr3_s0);
  assign opb_off  = mem_ctrl_pkg::opb_ctr_sel_t'(bus.index - mem_ctrl_pkg::reg_opb_s0);

  // ==========================================================================
  // Read multiplexer and index decode
  // ==========================================================================
  always_comb begin
    hit     = 1'b1;
    rd_word = '0;
    case (bus.index)
      mem_ctrl_pkg::reg_softaddr: rd_word = software_address_bits;
      mem_ctrl_pkg::reg_phyready: rd_word = {31'b0, phy_ready};
      mem_ctrl_pkg::reg_override: begin
        rd_word = {24'b0, cpu_override_en, 6'b0, cpu_override_sel};
      end
      mem_ctrl_pkg::reg_arbstate: begin
        rd_word = {24'b0, arbiter_conflict, 3'b0, arbiter_state};
      end
      mem_ctrl_pkg::reg_memstate: rd_word = {24'b0, mem_opb_state, mem_dram_state};
      mem_ctrl_pkg::reg_ddr3_s0, mem_ctrl_pkg::reg_ddr3_s1, mem_ctrl_pkg::reg_ddr3_s2,
      mem_ctrl_pkg::reg_ddr3_s3, mem_ctrl_pkg::reg_ddr3_s4, mem_ctrl_pkg::reg_ddr3_s5,
      mem_ctrl_pkg::reg_ddr3_s6, mem_ctrl_pkg::reg_ddr3_s7, mem_ctrl_pkg::reg_ddr3_sx: begin
        rd_word = ddr3_ctrs[ddr3_off];
      end
      mem_ctrl_pkg::reg_opb_s0, mem_ctrl_pkg::reg_opb_s1, mem_ctrl_pkg::reg_opb_s2,
      mem_ctrl_pkg::reg_opb_s3, mem_ctrl_pkg::reg_opb_s4, mem_ctrl_pkg::reg_opb_s5,
      mem_ctrl_pkg::reg_opb_sx: begin
        rd_word = opb_ctrs[opb_off];
      end
      mem_ctrl_pkg::reg_opb_ctr_rst:  rd_word = {31'b0, opb_ctr_rst};
      mem_ctrl_pkg::reg_ddr3_ctr_rst: rd_word = {31'b0, ddr3_ctr_rst};
      mem_ctrl_pkg::reg_opb_addr_lil: rd_word = ctrl_opb_addr_lil;
      mem_ctrl_pkg::reg_opb_addr_big: rd_word = ctrl_opb_addr_big;
      default: hit = 1'b0;
    endcase
  end

  // ==========================================================================
  // Response and writable registers
  // ==========================================================================
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      bus.ack               <= 1'b0;
      bus.err               <= 1'b0;
      bus.rdata             <= '0;
      software_address_bits <= '0;
      cpu_override_en       <= 1'b0;
      cpu_override_sel      <= 1'b0;
      opb_ctr_rst           <= 1'b0;
      ddr3_ctr_rst          <= 1'b0;
    end else begin
      bus.ack   <= bus.req && hit;
      bus.err   <= bus.req && !hit;
      // Read data is only driven in the acknowledge cycle of a read
      bus.rdata <= (bus.req && bus.rnw) ? rd_word : '0;
      if (bus.req && !bus.rnw) begin
        case (bus.index)
          mem_ctrl_pkg::reg_softaddr: begin
            for (int i = 0; i < opb_bus_pkg::opb_be_width; i++) begin
              if (bus.be[i]) begin
                software_address_bits[8*i +: 8] <= bus.wdata[8*i +: 8];
              end
            end
          end
          mem_ctrl_pkg::reg_override: begin
            if (bus.be[0]) begin
              cpu_override_en  <= bus.wdata[7];
              cpu_override_sel <= bus.wdata[0];
            end
          end
          mem_ctrl_pkg::reg_opb_ctr_rst: begin
            if (bus.be[0]) begin
              opb_ctr_rst <= bus.wdata[0];
            end
          end
          mem_ctrl_pkg::reg_ddr3_ctr_rst: begin
            if (bus.be[0]) begin
              ddr3_ctr_rst <= bus.wdata[0];
            end
          end
          // Status words ignore writes
          default: ;
        endcase
      end
    end
  end

endmodule

//--- source/mem_ctrl_monitor_top.sv
`timescale 1ns/1ps

module mem_ctrl_monitor_top (
  input  logic                                   OPB_Clk,
  input  logic                                   rst_n,
  input  logic [0:opb_bus_pkg::opb_addr_width-1] OPB_ABus,
  input  logic [0:opb_bus_pkg::opb_be_width-1]   OPB_BE,
  input  logic [0:opb_bus_pkg::opb_data_width-1] OPB_DBus,
  input  logic                                   OPB_RNW,
  input  logic                                   OPB_select,
  // Bursts are not supported, each beat is a separate access
  input  logic                                   OPB_seqAddr,
  output logic [0:opb_bus_pkg::opb_data_width-1] Sl_DBus,
  output logic                                   Sl_errAck,
  output logic                                   Sl_retry,
  output logic                                   Sl_toutSup,
  output logic                                   Sl_xferAck,
  input  mem_ctrl_pkg::state_code_t              mem_dram_state,
  input  mem_ctrl_pkg::state_code_t              mem_opb_state,
  input  mem_ctrl_pkg::state_code_t              arbiter_state,
  input  logic                                   arbiter_conflict,
  input  logic                                   phy_ready,
  input  opb_bus_pkg::opb_data_t                 ctrl_opb_addr_lil,
  input  opb_bus_pkg::opb_data_t                 ctrl_opb_addr_big,
  output opb_bus_pkg::opb_data_t                 software_address_bits,
  output logic                                   cpu_override_en,
  output logic                                   cpu_override_sel,
  output logic                                   opb_ctr_rst,
  output logic                                   ddr3_ctr_rst
);

  mem_ctrl_pkg::ddr3_ctr_array_t ddr3_ctrs;
  mem_ctrl_pkg::opb_ctr_array_t  opb_ctrs;

  opb_reg_if reg_bus ();

  opb_slave_decode u_decode (
    .OPB_Clk    (OPB_Clk),
    .rst_n      (rst_n),
    .OPB_ABus   (OPB_ABus),
    .OPB_BE     (OPB_BE),
    .OPB_DBus   (OPB_DBus),
    .OPB_RNW    (OPB_RNW),
    .OPB_select (OPB_select),
    .Sl_DBus    (Sl_DBus),
    .Sl_xferAck (Sl_xferAck),
    .Sl_errAck  (Sl_errAck),
    .Sl_retry   (Sl_retry),
    .Sl_toutSup (Sl_toutSup),
    .bus        (reg_bus.decoder)
  );

  ctrl_reg_file u_regs (
    .OPB_Clk               (OPB_Clk),
    .rst_n                 (rst_n),
    .bus                   (reg_bus.regs),
    .ddr3_ctrs             (ddr3_ctrs),
    .opb_ctrs              (opb_ctrs),
    .mem_dram_state        (mem_dram_state),
    .mem_opb_state         (mem_opb_state),
    .arbiter_state         (arbiter_state),
    .arbiter_conflict      (arbiter_conflict),
    .phy_ready             (phy_ready),
    .ctrl_opb_addr_lil     (ctrl_opb_addr_lil),
    .ctrl_opb_addr_big     (ctrl_opb_addr_big),
    .software_address_bits (software_address_bits),
    .cpu_override_en       (cpu_override_en),
    .cpu_override_sel      (cpu_override_sel),
    .opb_ctr_rst           (opb_ctr_rst),
    .ddr3_ctr_rst          (ddr3_ctr_rst)
  );

  state_occupancy_counters u_counters (
    .OPB_Clk        (OPB_Clk),
    .rst_n          (rst_n),
    .mem_dram_state (mem_dram_state),
    .mem_opb_state  (mem_opb_state),
    .opb_ctr_rst    (opb_ctr_rst),
    .ddr3_ctr_rst   (ddr3_ctr_rst),
    .ddr3_ctrs      (ddr3_ctrs),
    .opb_ctrs       (opb_ctrs)
  );

endmodule

//--- tb/mem_ctrl_monitor_props.sv
`timescale 1ns/1ps

module mem_ctrl_monitor_props (
  input logic OPB_Clk,
  input logic rst_n,
  input logic Sl_xferAck,
  input logic Sl_errAck,
  input logic req,
  input logic ack,
  input logic err
);

  int failures = 0;

  a_single_kind: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    !(Sl_xferAck && Sl_errAck))
    else begin
      failures++;
      $error("Sl_xferAck and Sl_errAck are high in the same cycle");
    end

  // A response lasts exactly one cycle
  a_one_cycle: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    (Sl_xferAck || Sl_errAck) |=> !(Sl_xferAck || Sl_errAck))
    else begin
      failures++;
      $error("OPB response is longer than one cycle");
    end

  a_req_answer: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    req |=> (ack || err))
    else begin
      failures++;
      $error("req was not answered by ack or err one cycle later");
    end

endmodule

bind opb_slave_decode mem_ctrl_monitor_props decode_props (
  .OPB_Clk    (OPB_Clk),
  .rst_n      (rst_n),
  .Sl_xferAck (Sl_xferAck),
  .Sl_errAck  (Sl_errAck),
  .req        (bus.req),
  .ack        (bus.ack),
  .err        (bus.err)
);

//--- tb/tb_mem_ctrl_monitor.sv
`timescale 1ns/1ps

module tb_mem_ctrl_monitor;

  localparam int resp_timeout = 16;
  localparam opb_bus_pkg::reg_index_t status_words [5] = '{
    mem_ctrl_pkg::reg_phyready, mem_ctrl_pkg::reg_arbstate, mem_ctrl_pkg::reg_memstate,
    mem_ctrl_pkg::reg_opb_addr_lil, mem_ctrl_pkg::reg_opb_addr_big};
  localparam opb_bus_pkg::opb_addr_t outside_addrs [3] = '{
    opb_bus_pkg::opb_base_addr - 32'd4, opb_bus_pkg::opb_high_addr, 32'h0};

  logic                                   OPB_Clk = 1'b0;
  logic                                   rst_n;
  logic [0:opb_bus_pkg::opb_addr_width-1] OPB_ABus;
  logic [0:opb_bus_pkg::opb_be_width-1]   OPB_BE;
  logic [0:opb_bus_pkg::opb_data_width-1] OPB_DBus, Sl_DBus;
  logic OPB_RNW, OPB_select, OPB_seqAddr, Sl_errAck, Sl_retry, Sl_toutSup, Sl_xferAck;
  logic arbiter_conflict, phy_ready, cpu_override_en, cpu_override_sel;
  logic opb_ctr_rst, ddr3_ctr_rst;
  mem_ctrl_pkg::state_code_t mem_dram_state, mem_opb_state, arbiter_state;
  opb_bus_pkg::opb_data_t    ctrl_opb_addr_lil, ctrl_opb_addr_big, software_address_bits;

  // Shadow of the writable words and model of the occupancy counters
  opb_bus_pkg::opb_data_t   soft_sh;
  logic                     ovr_en_sh, ovr_sel_sh, opb_clr_sh, ddr3_clr_sh;
  mem_ctrl_pkg::ctr_value_t ddr3_model [mem_ctrl_pkg::ddr3_ctr_num];
  mem_ctrl_pkg::ctr_value_t opb_model [mem_ctrl_pkg::opb_ctr_num];
  opb_bus_pkg::opb_data_t   exp_q[$], act_q[$];
  string                    name_q[$];
  int                       value_errors = 0;
  int                       other_errors = 0;
  logic                     states_running = 1'b0;

  mem_ctrl_monitor_top UUT (.*);

  always #2 OPB_Clk = ~OPB_Clk;

  // Codes without a counter of their own land in the last entry
  always @(posedge OPB_Clk) begin
    if (!rst_n || ddr3_clr_sh) begin
      ddr3_model = '{default: '0};
    end else if (mem_dram_state < mem_ctrl_pkg::ddr3_ctr_num - 1) begin
      ddr3_model[mem_dram_state] += 1;
    end else begin
      ddr3_model[mem_ctrl_pkg::ddr3_ctr_num - 1] += 1;
    end
    if (!rst_n || opb_clr_sh) begin
      opb_model = '{default: '0};
    end else if (mem_opb_state < mem_ctrl_pkg::opb_ctr_num - 1) begin
      opb_model[mem_opb_state] += 1;
    end else begin
      opb_model[mem_ctrl_pkg::opb_ctr_num - 1] += 1;
    end
  end

  always @(negedge OPB_Clk) begin
    if (states_running) begin
      mem_dram_state = 4'($urandom_range(11, 0));
      mem_opb_state  = 4'($urandom_range(9, 0));
    end
  end

  task automatic check_value(input string name, input opb_bus_pkg::opb_data_t exp,
                             input opb_bus_pkg::opb_data_t act);
    assert (act == exp) else begin
      value_errors++;
      $display("** Error: %s expected 0x%08h, got 0x%08h", name, exp, act);
    end
  endtask

  always @(negedge OPB_Clk) begin
    while (act_q.size() > 0) begin
      check_value(name_q[0], exp_q[0], act_q[0]);
      exp_q.delete(0);
      act_q.delete(0);
      name_q.delete(0);
    end
  end

  function automatic opb_bus_pkg::opb_data_t expected_read(input opb_bus_pkg::reg_index_t idx);
    case (idx)
      mem_ctrl_pkg::reg_softaddr:     return soft_sh;
      mem_ctrl_pkg::reg_phyready:     return {31'b0, phy_ready};
      mem_ctrl_pkg::reg_override:     return {24'b0, ovr_en_sh, 6'b0, ovr_sel_sh};
      mem_ctrl_pkg::reg_arbstate:     return {24'b0, arbiter_conflict, 3'b0, arbiter_state};
      mem_ctrl_pkg::reg_memstate:     return {24'b0, mem_opb_state, mem_dram_state};
      mem_ctrl_pkg::reg_opb_ctr_rst:  return {31'b0, opb_clr_sh};
      mem_ctrl_pkg::reg_ddr3_ctr_rst: return {31'b0, ddr3_clr_sh};
      mem_ctrl_pkg::reg_opb_addr_lil: return ctrl_opb_addr_lil;
      mem_ctrl_pkg::reg_opb_addr_big: return ctrl_opb_addr_big;
      default: begin
        if (idx >= mem_ctrl_pkg::reg_ddr3_s0 && idx <= mem_ctrl_pkg::reg_ddr3_sx) begin
          return ddr3_model[idx - mem_ctrl_pkg::reg_ddr3_s0];
        end
        if (idx >= mem_ctrl_pkg::reg_opb_s0 && idx <= mem_ctrl_pkg::reg_opb_sx) begin
          return opb_model[idx - mem_ctrl_pkg::reg_opb_s0];
        end
        return '0;
      end
    endcase
  endfunction

  function automatic void apply_write(input opb_bus_pkg::reg_index_t idx,
                                      input opb_bus_pkg::opb_be_t be,
                                      input opb_bus_pkg::opb_data_t data);
    for (int i = 0; i < 4; i++) begin
      if (idx == mem_ctrl_pkg::reg_softaddr && be[i]) begin
        soft_sh[8*i +: 8] = data[8*i +: 8];
      end
    end
    if (be[0]) begin
      case (idx)
        mem_ctrl_pkg::reg_override: begin
          ovr_en_sh  = data[7];
          ovr_sel_sh = data[0];
        end
        mem_ctrl_pkg::reg_opb_ctr_rst:  opb_clr_sh = data[0];
        mem_ctrl_pkg::reg_ddr3_ctr_rst: ddr3_clr_sh = data[0];
        default: ;
      endcase
    end
  endfunction

  // ==========================================================================
  // OPB access, entered and left on a falling edge
  // ==========================================================================
  task automatic bus_cycle(input opb_bus_pkg::opb_addr_t addr, input logic rnw,
                           input opb_bus_pkg::opb_be_t be, input opb_bus_pkg::opb_data_t wdata,
                           output logic ack, output logic err,
                           output opb_bus_pkg::opb_data_t rdata,
                           output opb_bus_pkg::opb_data_t snap, output int cycles);
    opb_bus_pkg::reg_index_t idx;
    idx = opb_bus_pkg::reg_index_t'((addr - opb_bus_pkg::opb_base_addr) >> 2);
    ack = 1'b0;
    err = 1'b0;
    rdata = '0;
    snap = '0;
    cycles = 0;
    OPB_ABus = addr;
    OPB_BE = be;
    OPB_DBus = wdata;
    OPB_RNW = rnw;
    OPB_select = 1'b1;
    while (cycles < resp_timeout && !ack && !err) begin
      @(negedge OPB_Clk);
      cycles++;
      // Counter reads return the value registered at the select edge
      if (cycles == 1) begin
        snap = expected_read(idx);
      end
      ack = Sl_xferAck;
      err = Sl_errAck;
      rdata = Sl_DBus;
    end
    if (ack && !rnw) begin
      apply_write(idx, be, wdata);
    end
    OPB_select = 1'b0;
    repeat (2) @(negedge OPB_Clk);
  endtask

  task automatic check_outputs();
    check_value("software_address_bits", soft_sh, software_address_bits);
    check_value("cpu_override_en", 32'(ovr_en_sh), 32'(cpu_override_en));
    check_value("cpu_override_sel", 32'(ovr_sel_sh), 32'(cpu_override_sel));
    check_value("opb_ctr_rst", 32'(opb_clr_sh), 32'(opb_ctr_rst));
    check_value("ddr3_ctr_rst", 32'(ddr3_clr_sh), 32'(ddr3_ctr_rst));
    check_value("Sl_retry", '0, 32'(Sl_retry));
    check_value("Sl_toutSup", '0, 32'(Sl_toutSup));
  endtask

  task automatic opb_write(input opb_bus_pkg::reg_index_t idx, input opb_bus_pkg::opb_be_t be,
                           input opb_bus_pkg::opb_data_t data);
    logic                   ack, err;
    opb_bus_pkg::opb_data_t rdata, snap;
    int                     cycles;
    bus_cycle(opb_bus_pkg::opb_base_addr + {idx, 2'b00}, 1'b0, be, data, ack, err, rdata, snap,
              cycles);
    assert (ack && !err && cycles == 2) else begin
      other_errors++;
      $display("Write to word %0d was not acknowledged two cycles after select", idx);
    end
    check_value("Sl_DBus on write", '0, rdata);
    check_outputs();
  endtask

  task automatic opb_read(input opb_bus_pkg::reg_index_t idx, input logic expect_err);
    logic                   ack, err;
    opb_bus_pkg::opb_data_t rdata, snap;
    int                     cycles;
    bus_cycle(opb_bus_pkg::opb_base_addr + {idx, 2'b00}, 1'b1, 4'hF, '0, ack, err, rdata, snap,
              cycles);
    assert (ack == !expect_err && err == expect_err && cycles == 2) else begin
      other_errors++;
      $display("Read of word %0d got the wrong response kind or none two cycles after select",
               idx);
    end
    exp_q.push_back(expect_err ? '0 : snap);
    act_q.push_back(rdata);
    name_q.push_back($sformatf("Sl_DBus word %0d", idx));
  endtask

  initial begin
    logic                   ack, err;
    opb_bus_pkg::opb_data_t rdata, snap;
    int                     cycles;
    void'($urandom(43549));
    rst_n = 1'b0;
    {OPB_ABus, OPB_BE, OPB_DBus, OPB_RNW, OPB_select, OPB_seqAddr} = '0;
    {mem_dram_state, mem_opb_state, arbiter_state, arbiter_conflict, phy_ready} = '0;
    {ctrl_opb_addr_lil, ctrl_opb_addr_big} = '0;
    {soft_sh, ovr_en_sh, ovr_sel_sh, opb_clr_sh, ddr3_clr_sh} = '0;
    repeat (8) @(negedge OPB_Clk);
    rst_n = 1'b1;
    @(negedge OPB_Clk);

    check_outputs();
    opb_read(mem_ctrl_pkg::reg_softaddr, 1'b0);
    opb_read(mem_ctrl_pkg::reg_override, 1'b0);
    opb_read(mem_ctrl_pkg::reg_opb_ctr_rst, 1'b0);
    opb_read(mem_ctrl_pkg::reg_ddr3_ctr_rst, 1'b0);

    repeat (24) begin
      opb_write(mem_ctrl_pkg::reg_softaddr, 4'($urandom_range(15, 0)), $urandom);
      opb_read(mem_ctrl_pkg::reg_softaddr, 1'b0);
    end

    opb_write(mem_ctrl_pkg::reg_override, 4'h1, 32'h0000_0081);
    opb_write(mem_ctrl_pkg::reg_override, 4'hE, 32'h0000_0000);
    opb_read(mem_ctrl_pkg::reg_override, 1'b0);
    opb_write(mem_ctrl_pkg::reg_override, 4'hF, 32'hFFFF_FF01);
    opb_read(mem_ctrl_pkg::reg_override, 1'b0);
    for (int w = mem_ctrl_pkg::reg_opb_ctr_rst; w <= mem_ctrl_pkg::reg_ddr3_ctr_rst; w++) begin
      opb_write(8'(w), 4'h1, 32'h1);
      opb_write(8'(w), 4'hE, 32'h0);
      opb_read(8'(w), 1'b0);
      opb_write(8'(w), 4'h1, 32'h0);
      opb_read(8'(w), 1'b0);
    end

    repeat (6) begin
      phy_ready = 1'($urandom);
      arbiter_conflict = 1'($urandom);
      arbiter_state = 4'($urandom);
      mem_dram_state = 4'($urandom);
      mem_opb_state = 4'($urandom);
      ctrl_opb_addr_lil = $urandom;
      ctrl_opb_addr_big = $urandom;
      foreach (status_words[i]) begin
        opb_read(status_words[i], 1'b0);
        opb_write(status_words[i], 4'hF, $urandom);
        opb_read(status_words[i], 1'b0);
      end
    end

    states_running = 1'b1;
    repeat (64) @(negedge OPB_Clk);
    for (int w = mem_ctrl_pkg::reg_ddr3_s0; w <= mem_ctrl_pkg::reg_opb_sx; w++) begin
      opb_read(8'(w), 1'b0);
    end
    opb_write(mem_ctrl_pkg::reg_ddr3_ctr_rst, 4'h1, 32'h1);
    opb_write(mem_ctrl_pkg::reg_opb_ctr_rst, 4'h1, 32'h1);
    for (int w = mem_ctrl_pkg::reg_ddr3_s0; w <= mem_ctrl_pkg::reg_opb_sx; w++) begin
      opb_read(8'(w), 1'b0);
    end
    opb_write(mem_ctrl_pkg::reg_ddr3_ctr_rst, 4'h1, 32'h0);
    opb_write(mem_ctrl_pkg::reg_opb_ctr_rst, 4'h1, 32'h0);
    repeat (40) @(negedge OPB_Clk);
    for (int w = mem_ctrl_pkg::reg_ddr3_s0; w <= mem_ctrl_pkg::reg_opb_sx; w++) begin
      opb_read(8'(w), 1'b0);
    end
    states_running = 1'b0;

    opb_read(8'd25, 1'b1);
    opb_read(8'd255, 1'b1);
    // Outside the window the only correct outcome is the timeout
    foreach (outside_addrs[i]) begin
      bus_cycle(outside_addrs[i], 1'b1, 4'hF, '0, ack, err, rdata, snap, cycles);
      assert (!ack && !err) else begin
        other_errors++;
        $display("Address 0x%08h outside the window got a response", outside_addrs[i]);
      end
    end

    repeat (2) @(negedge OPB_Clk);
    other_errors += UUT.u_decode.decode_props.failures;
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
source/opb_bus_pkg.sv
source/mem_ctrl_pkg.sv
source/opb_reg_if.sv
source/opb_slave_decode.sv
source/state_occupancy_counters.sv
source/ctrl_reg_file.sv
source/mem_ctrl_monitor_top.sv
tb/mem_ctrl_monitor_props.sv
tb/tb_mem_ctrl_monitor.sv

//--- run_sim.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_ctrl_monitor \
  -f filelist.f -Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
